// ==== verilog.f ====
+incdir+source
source/wb_pkg.sv
source/soc_map_pkg.sv
source/wb_interconnect.sv
source/main_mem.sv
source/dma_engine.sv
source/soc_top.sv
bench/soc_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SoC testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module soc_top_tb \
  -Mdir obj_dir -o soc_top_tb > build.log 2>&1 &&
./obj_dir/soc_top_tb > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log &&
{ echo "Simulation failed"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

// ==== bench/soc_top_tb.sv ====
/* Table-driven testbench for the SoC bus core.
   Host steps run one at a time, each waits for ready. Expected values
   come from a local word model kept while the table is built. */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_top_tb
  import wb_pkg::*;
;

  localparam int IDX_W = $clog2(`SOC_MEM_WORDS);
  localparam logic [31:0] DMA_SRC  = `SOC_DMA_BASE + 32'h0;
  localparam logic [31:0] DMA_DST  = `SOC_DMA_BASE + 32'h4;
  localparam logic [31:0] DMA_LEN  = `SOC_DMA_BASE + 32'h8;
  localparam logic [31:0] DMA_CTRL = `SOC_DMA_BASE + 32'hC;
  localparam logic [31:0] STATUS_BUSY = 32'h1;
  localparam logic [31:0] STATUS_DONE = 32'h2;
  localparam logic [31:0] SRC_BASE = 32'h0000_0400;
  localparam logic [31:0] DST_BASE = 32'h0000_0800;
  localparam int COPY_LEN = 8;
  localparam logic [3:0] MIX_STRB [6] = '{4'b0001, 4'b0110, 4'b1000,
                                           4'b1010, 4'b0101, 4'b1100};

  typedef enum logic [1:0] {
    K_WRITE,
    K_READ,
    K_WAIT_IRQ,
    K_CLEAR_IRQ
  } step_kind_e;

  typedef struct packed {
    step_kind_e  kind;
    logic [31:0] addr;
    logic [3:0]  strb;
    logic [31:0] data;
    logic [31:0] exp_val;
  } step_t;

  logic        clk = 1'b0;
  logic        reset_i;
  logic        host_req_valid_i;
  wb_req_t     host_req;
  logic        host_req_ready_o;
  logic [31:0] host_rdata_o;
  logic        irq_o;
  logic        irq_clear_i;

  step_t       steps[$];
  logic [31:0] model [`SOC_MEM_WORDS];
  logic [15:0] lfsr_q = 16'd30827;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000;

  always #10 clk = ~clk;

  soc_top u_soc_top (
    .clk              (clk),
    .reset_i          (reset_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req),
    .host_req_ready_o (host_req_ready_o),
    .host_rdata_o     (host_rdata_o),
    .irq_o            (irq_o),
    .irq_clear_i      (irq_clear_i)
  );

  ////////////////////////////////////////
  // Stimulus data and reference model
  ////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [31:0] w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr_q[15]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic in_mem_region(input logic [31:0] addr);
    return (addr >> `SOC_REGION_SHIFT) == (`SOC_MEM_BASE >> `SOC_REGION_SHIFT);
  endfunction

  task automatic add_step(input step_kind_e kind, input logic [31:0] addr,
                          input logic [3:0] strb, input logic [31:0] data,
                          input logic [31:0] exp_val);
    step_t st;
    st.kind    = kind;
    st.addr    = addr;
    st.strb    = strb;
    st.data    = data;
    st.exp_val = exp_val;
    steps.push_back(st);
  endtask

  // Byte merge into the model, unmapped writes are dropped
  task automatic add_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    add_step(K_WRITE, addr, strb, data, '0);
    if (in_mem_region(addr)) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[addr[IDX_W+1:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic add_mem_read(input logic [31:0] addr);
    add_step(K_READ, addr, 4'hF, '0, model[addr[IDX_W+1:2]]);
  endtask

  task automatic apply_copy(input logic [31:0] src, input logic [31:0] dst, input int len);
    for (int i = 0; i < len; i++) begin
      model[dst[IDX_W+1:2] + IDX_W'(i)] = model[src[IDX_W+1:2] + IDX_W'(i)];
    end
  endtask

  task automatic build_table();
    logic [31:0] w;
    logic [31:0] a;
    for (int i = 0; i < `SOC_MEM_WORDS; i++) begin
      model[i] = '0;
    end
    add_step(K_READ, DMA_CTRL, 4'hF, '0, '0);
    // Full word first, then a partial overwrite
    for (int i = 0; i < 6; i++) begin
      a = 32'h100 + 32'(4 * i);
      random_word(w);
      add_write(a, 4'hF, w);
      random_word(w);
      add_write(a, MIX_STRB[i], w);
    end
    for (int i = 0; i < 6; i++) begin
      add_mem_read(32'h100 + 32'(4 * i));
    end
    // Unmapped region, low bits match live memory words
    add_step(K_READ, 32'h0002_0100, 4'hF, '0, '0);
    random_word(w);
    add_write(32'h0002_0100, 4'hF, w);
    add_write(32'h8000_0104, 4'hF, w);
    add_mem_read(32'h100);
    add_mem_read(32'h104);
    // Copy source and a word just past the destination
    for (int i = 0; i < COPY_LEN; i++) begin
      random_word(w);
      add_write(SRC_BASE + 32'(4 * i), 4'hF, w);
    end
    random_word(w);
    add_write(DST_BASE + 32'(4 * COPY_LEN), 4'hF, w);
    add_write(DMA_SRC, 4'hF, SRC_BASE);
    add_write(DMA_DST, 4'hF, DST_BASE);
    add_write(DMA_LEN, 4'hF, 32'(COPY_LEN));
    add_write(DMA_CTRL, 4'hF, 32'h1);
    // Host traffic while the copy runs
    add_mem_read(32'h100);
    add_mem_read(32'h104);
    add_mem_read(32'h108);
    add_step(K_READ, DMA_CTRL, 4'hF, '0, STATUS_BUSY);
    add_write(DMA_LEN, 4'hF, 32'd12);
    add_step(K_WAIT_IRQ, '0, '0, '0, 32'h1);
    apply_copy(SRC_BASE, DST_BASE, COPY_LEN);
    add_step(K_READ, DMA_CTRL, 4'hF, '0, STATUS_DONE);
    add_step(K_CLEAR_IRQ, '0, '0, '0, 32'h0);
    for (int i = 0; i <= COPY_LEN; i++) begin
      add_mem_read(DST_BASE + 32'(4 * i));
    end
  endtask

  ////////////////////////////////////////
  // Host port and IRQ drivers
  ////////////////////////////////////////

  // Entered and left on a falling edge
  task automatic host_access(input logic we, input logic [3:0] strb,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    host_req.we      = we;
    host_req.strb    = strb;
    host_req.addr    = addr;
    host_req.wdata   = wdata;
    host_req_valid_i = 1'b1;
    do begin
      @(negedge clk);
    end while (!host_req_ready_o);
    rdata = host_rdata_o;
    @(negedge clk);
    host_req_valid_i = 1'b0;
  endtask

  task automatic wait_irq();
    while (!irq_o) begin
      @(negedge clk);
    end
  endtask

  task automatic pulse_irq_clear();
    irq_clear_i = 1'b1;
    @(negedge clk);
    irq_clear_i = 1'b0;
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: no result after %0d cycles, a handshake never completed",
               cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    step_t       st;
    logic [31:0] rdata;
    reset_i          = 1'b1;
    host_req_valid_i = 1'b0;
    host_req         = '0;
    irq_clear_i      = 1'b0;
    build_table();
    cycle_limit = 40 * steps.size() + 10;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    @(negedge clk);
    checks = checks + 2;
    if (irq_o !== 1'b0) begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: irq_o is %b after reset", $time, irq_o);
    end
    if (host_req_ready_o !== 1'b0) begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: ready is %b after reset", $time, host_req_ready_o);
    end
    for (int i = 0; i < steps.size(); i++) begin
      st = steps[i];
      case (st.kind)
        K_WRITE: host_access(1'b1, st.strb, st.addr, st.data, rdata);
        K_READ: begin
          host_access(1'b0, st.strb, st.addr, '0, rdata);
          checks = checks + 1;
          if (rdata !== st.exp_val) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: step %0d read 0x%08h gave 0x%08h, expected 0x%08h",
                     $time, i, st.addr, rdata, st.exp_val);
          end
        end
        K_WAIT_IRQ: wait_irq();
        default: begin
          // Interrupt must still be pending until the clear pulse
          checks = checks + 1;
          if (irq_o !== 1'b1) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: step %0d irq_o is %b before clear",
                     $time, i, irq_o);
          end
          pulse_irq_clear();
          checks = checks + 1;
          if (irq_o !== st.exp_val[0]) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: step %0d irq_o is %b after clear",
                     $time, i, irq_o);
          end
        end
      endcase
    end
    $display("Summary: %0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/soc_top.sv ====
/* SoC bus core: host port, DMA engine, interconnect and memory.
   Host request must stay stable while valid is high and ready is low. */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_top
  import wb_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   host_req_valid_i,
  input  wb_req_t                host_req_i,
  output logic                   host_req_ready_o,
  output logic [`SOC_DATA_W-1:0] host_rdata_o,
  output logic                   irq_o,
  input  logic                   irq_clear_i
);

  wb_req_t host_req;
  wb_rsp_t host_rsp;
  wb_req_t dma_mst_req;
  wb_rsp_t dma_mst_rsp;
  wb_req_t mem_req;
  wb_rsp_t mem_rsp;
  wb_req_t regs_req;
  wb_rsp_t regs_rsp;

  // Valid stands in for cyc
  assign host_req = '{cyc:   host_req_valid_i,
                      we:    host_req_i.we,
                      strb:  host_req_i.strb,
                      addr:  host_req_i.addr,
                      wdata: host_req_i.wdata};

  assign host_req_ready_o = host_rsp.ack;
  assign host_rdata_o     = host_rsp.rdata;

  wb_interconnect u_wb_interconnect (
    .clk        (clk),
    .reset_i    (reset_i),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .dma_req_i  (dma_mst_req),
    .dma_rsp_o  (dma_mst_rsp),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .regs_req_o (regs_req),
    .regs_rsp_i (regs_rsp)
  );

  main_mem u_main_mem (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

  dma_engine u_dma_engine (
    .clk         (clk),
    .reset_i     (reset_i),
    .slv_req_i   (regs_req),
    .slv_rsp_o   (regs_rsp),
    .mst_req_o   (dma_mst_req),
    .mst_rsp_i   (dma_mst_rsp),
    .irq_o       (irq_o),
    .irq_clear_i (irq_clear_i)
  );

endmodule

`default_nettype wire

// ==== source/dma_engine.sv ====
/* Word-copy DMA with a register slave and a bus master port.
   SRC, DST and LEN take full words and advance in place during a copy,
   so LEN reads zero once the copy is done. Writes while busy are dropped. */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module dma_engine
  import wb_pkg::*;
  import soc_map_pkg::*;
(
  input  logic    clk,
  input  logic    reset_i,
  input  wb_req_t slv_req_i,
  output wb_rsp_t slv_rsp_o,
  output wb_req_t mst_req_o,
  input  wb_rsp_t mst_rsp_i,
  output logic    irq_o,
  input  logic    irq_clear_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  localparam logic [`SOC_ADDR_W-1:0] STEP = `SOC_ADDR_W'(4);

  state_e                 state_q;
  logic [`SOC_ADDR_W-1:0] src_q;
  logic [`SOC_ADDR_W-1:0] dst_q;
  logic [`SOC_DATA_W-1:0] len_q;
  logic [`SOC_DATA_W-1:0] data_q;
  logic                   done_q;
  logic                   irq_q;
  logic                   slv_ack_q;
  logic [`SOC_DATA_W-1:0] slv_rdata_q;
  logic                   slv_access;
  logic                   slv_write;
  dma_reg_e               reg_sel;
  dma_status_t            status;

  ////////////////////////////////////////
  // Register slave
  ////////////////////////////////////////

  assign slv_access = slv_req_i.cyc && !slv_ack_q;
  assign slv_write  = slv_access && slv_req_i.we;
  assign reg_sel    = dma_reg_e'(slv_req_i.addr[3:2]);
  assign status     = '{rsvd: '0, done: done_q, busy: (state_q != ST_IDLE)};

  always_ff @(posedge clk) begin
    if (slv_access) begin
      case (reg_sel)
        SRC:     slv_rdata_q <= src_q;
        DST:     slv_rdata_q <= dst_q;
        LEN:     slv_rdata_q <= len_q;
        default: slv_rdata_q <= status;
      endcase
    end
  end

  assign slv_rsp_o = '{ack: slv_ack_q, rdata: slv_rdata_q};
  assign irq_o     = irq_q;

  ////////////////////////////////////////
  // Copy sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
      done_q    <= 1'b0;
      irq_q     <= 1'b0;
      slv_ack_q <= 1'b0;
    end else begin
      slv_ack_q <= slv_access;
      if (irq_clear_i) begin
        irq_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (slv_write) begin
            case (reg_sel)
              SRC: src_q <= slv_req_i.wdata;
              DST: dst_q <= slv_req_i.wdata;
              LEN: len_q <= slv_req_i.wdata;
              // CTRL bit 0 starts a copy
              default: begin
                if (slv_req_i.wdata[0] && len_q != '0) begin
                  state_q <= ST_READ;
                  done_q  <= 1'b0;
                end
              end
            endcase
          end
        end
        ST_READ: begin
          if (mst_rsp_i.ack) begin
            state_q <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (mst_rsp_i.ack) begin
            src_q <= src_q + STEP;
            dst_q <= dst_q + STEP;
            len_q <= len_q - 1'b1;
            if (len_q == `SOC_DATA_W'(1)) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
              irq_q   <= 1'b1;
            end else begin
              state_q <= ST_READ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Word in flight between read and write
  always_ff @(posedge clk) begin
    if (state_q == ST_READ && mst_rsp_i.ack) begin
      data_q <= mst_rsp_i.rdata;
    end
  end

  always_comb begin
    mst_req_o.cyc   = (state_q != ST_IDLE);
    mst_req_o.we    = (state_q == ST_WRITE);
    mst_req_o.strb  = '1;
    mst_req_o.addr  = (state_q == ST_WRITE) ? dst_q : src_q;
    mst_req_o.wdata = data_q;
  end

  a_mst_stable: assert property (
    @(posedge clk) disable iff (reset_i)
      (mst_req_o.cyc && !mst_rsp_i.ack) |=>
        (mst_req_o.cyc && $stable(mst_req_o.we) && $stable(mst_req_o.addr))
  );

endmodule

`default_nettype wire

// ==== source/main_mem.sv ====
/* Single-port word memory, byte strobes on write.
   Ack follows cyc by one cycle; the address wraps at SOC_MEM_WORDS.
   Contents power up as zero. */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module main_mem
  import wb_pkg::*;
(
  input  logic    clk,
  input  logic    reset_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`SOC_MEM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_MEM_WORDS];
  logic [IDX_W-1:0]       idx;
  logic                   access;
  logic                   ack_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  initial begin
    for (int i = 0; i < `SOC_MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign idx    = req_i.addr[IDX_W+1:2];
  // cyc in the ack cycle is the tail of the same transfer
  assign access = req_i.cyc && !ack_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= mem[idx];
      if (req_i.we) begin
        for (int b = 0; b < `SOC_DATA_W/8; b++) begin
          if (req_i.strb[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

  a_single_ack: assert property (
    @(posedge clk) disable iff (reset_i) ack_q |=> !ack_q
  );

endmodule

`default_nettype wire

// ==== source/wb_interconnect.sv ====
/* Two-master shared bus with round-robin arbitration.
   A grant is locked from the first cyc cycle until ack. The DMA master
   sees its own register region as unmapped. */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module wb_interconnect
  import wb_pkg::*;
  import soc_map_pkg::*;
(
  input  logic    clk,
  input  logic    reset_i,
  input  wb_req_t host_req_i,
  output wb_rsp_t host_rsp_o,
  input  wb_req_t dma_req_i,
  output wb_rsp_t dma_rsp_o,
  output wb_req_t mem_req_o,
  input  wb_rsp_t mem_rsp_i,
  output wb_req_t regs_req_o,
  input  wb_rsp_t regs_rsp_i
);

  localparam int REGION_W = `SOC_ADDR_W - `SOC_REGION_SHIFT;
  localparam logic [REGION_W-1:0] MEM_REGION = REGION_W'(`SOC_MEM_BASE >> `SOC_REGION_SHIFT);
  localparam logic [REGION_W-1:0] DMA_REGION = REGION_W'(`SOC_DMA_BASE >> `SOC_REGION_SHIFT);

  logic                locked_q;
  master_id_e          grant_q;
  master_id_e          pick;
  master_id_e          gnt;
  wb_req_t             gnt_req;
  wb_rsp_t             sel_rsp;
  slave_sel_e          sel;
  logic [REGION_W-1:0] region;
  logic                unm_ack_q;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // On a tie the last granted master loses
  always_comb begin
    if (host_req_i.cyc && dma_req_i.cyc) begin
      if (grant_q == HOST) begin
        pick = DMA;
      end else begin
        pick = HOST;
      end
    end else if (dma_req_i.cyc) begin
      pick = DMA;
    end else begin
      pick = HOST;
    end
  end

  assign gnt     = locked_q ? grant_q : pick;
  assign gnt_req = (gnt == HOST) ? host_req_i : dma_req_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      locked_q  <= 1'b0;
      grant_q   <= HOST;
      unm_ack_q <= 1'b0;
    end else begin
      unm_ack_q <= gnt_req.cyc && (sel == NONE) && !unm_ack_q;
      if (!locked_q && gnt_req.cyc) begin
        locked_q <= 1'b1;
        grant_q  <= pick;
      end else if (locked_q && sel_rsp.ack) begin
        locked_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Decode and routing
  ////////////////////////////////////////

  assign region = gnt_req.addr[`SOC_ADDR_W-1:`SOC_REGION_SHIFT];

  always_comb begin
    if (region == MEM_REGION) begin
      sel = MEM;
    end else if (region == DMA_REGION && gnt == HOST) begin
      sel = DMA_REGS;
    end else begin
      sel = NONE;
    end
  end

  always_comb begin
    mem_req_o      = gnt_req;
    mem_req_o.cyc  = gnt_req.cyc && (sel == MEM);
    regs_req_o     = gnt_req;
    regs_req_o.cyc = gnt_req.cyc && (sel == DMA_REGS);
  end

  // Unmapped responder reads zero
  always_comb begin
    case (sel)
      MEM:      sel_rsp = mem_rsp_i;
      DMA_REGS: sel_rsp = regs_rsp_i;
      default:  sel_rsp = '{ack: unm_ack_q, rdata: '0};
    endcase
  end

  always_comb begin
    host_rsp_o = '0;
    dma_rsp_o  = '0;
    if (gnt == HOST) begin
      host_rsp_o = sel_rsp;
    end else begin
      dma_rsp_o = sel_rsp;
    end
  end

  // Grant stays put while the owner waits for ack
  a_grant_held: assert property (
    @(posedge clk) disable iff (reset_i)
      (gnt_req.cyc && !sel_rsp.ack) |=> (gnt == $past(gnt))
  );

endmodule

`default_nettype wire

// ==== source/soc_map_pkg.sv ====
/* Slave selection and the DMA register layout.
   Register offsets are decoded from addr[3:2] only. */
`default_nettype none
`include "soc_cfg.svh"

package soc_map_pkg;

  typedef enum logic [1:0] {
    MEM      = 2'd0,
    DMA_REGS = 2'd1,
    NONE     = 2'd2
  } slave_sel_e;

  // DMA register offsets, word index
  typedef enum logic [1:0] {
    SRC  = 2'd0,
    DST  = 2'd1,
    LEN  = 2'd2,
    CTRL = 2'd3
  } dma_reg_e;

  typedef struct packed {
    logic [`SOC_DATA_W-3:0] rsvd;
    logic                   done;
    logic                   busy;
  } dma_status_t;

endpackage

`default_nettype wire

// ==== source/wb_pkg.sv ====
/* Request and response types of the shared Wishbone-style bus.
   A master holds every request field until it sees ack. */
`default_nettype none
`include "soc_cfg.svh"

package wb_pkg;

  // One bus request, driven by a master
  typedef struct packed {
    logic                      cyc;
    logic                      we;
    logic [`SOC_DATA_W/8-1:0]  strb;
    logic [`SOC_ADDR_W-1:0]    addr;
    logic [`SOC_DATA_W-1:0]    wdata;
  } wb_req_t;

  // One bus response, ack lasts a single cycle
  typedef struct packed {
    logic                      ack;
    logic [`SOC_DATA_W-1:0]    rdata;
  } wb_rsp_t;

  typedef enum logic {
    HOST = 1'b0,
    DMA  = 1'b1
  } master_id_e;

endpackage

`default_nettype wire

// ==== source/soc_cfg.svh ====
/* Bus widths, memory depth and region map of the SoC.
   Regions are decoded on the address bits above SOC_REGION_SHIFT, so
   memory aliases inside its own 64 KB region. */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Main memory depth in words
`define SOC_MEM_WORDS 1024

// Region map
`define SOC_MEM_BASE 32'h0000_0000
`define SOC_DMA_BASE 32'h0001_0000
`define SOC_REGION_SHIFT 16

`endif
